// ==== Makefile ====
TOP := tb_periph_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f project.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== hw/addr_decoder.sv ====
/* address decoder, strobes one target per request
   and merges the target read data into a response one cycle later */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module addr_decoder import subsys_pkg::*; (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     valid_i,
  input  bus_req_t req_i,
  output logic     rom_sel_o,
  output logic     clint_sel_o,
  output logic     spm_sel_o,
  output bus_req_t tgt_req_o,
  input  data_t    rom_rdata_i,
  input  data_t    clint_rdata_i,
  input  data_t    spm_rdata_i,
  output logic     valid_o,
  output bus_rsp_t rsp_o
);

  localparam addr_t ROM_BASE   = `SUBSYS_ROM_BASE;
  localparam addr_t ROM_END    = ROM_BASE + `SUBSYS_ROM_WORDS * 8;
  localparam addr_t CLINT_BASE = `SUBSYS_CLINT_BASE;
  localparam addr_t CLINT_END  = CLINT_BASE + `SUBSYS_CLINT_LEN;
  localparam addr_t SPM_BASE   = `SUBSYS_SPM_BASE;
  localparam addr_t SPM_END    = SPM_BASE + `SUBSYS_SPM_WORDS * 8;

  target_e tgt;
  target_e tgt_q;
  logic    valid_q;
  logic    err_q;
  logic    we_q;

  // --------------------
  // request side
  // --------------------
  always_comb begin
    if (req_i.addr >= ROM_BASE && req_i.addr < ROM_END) begin
      tgt = TGT_ROM;
    end else if (req_i.addr >= CLINT_BASE && req_i.addr < CLINT_END) begin
      tgt = TGT_CLINT;
    end else if (req_i.addr >= SPM_BASE && req_i.addr < SPM_END) begin
      tgt = TGT_SPM;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // rom has nothing to do on a write
  assign rom_sel_o   = valid_i && tgt == TGT_ROM && !req_i.we;
  assign clint_sel_o = valid_i && tgt == TGT_CLINT;
  assign spm_sel_o   = valid_i && tgt == TGT_SPM;
  assign tgt_req_o   = req_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      tgt_q   <= TGT_NONE;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= valid_i;
      tgt_q   <= tgt;
      err_q   <= valid_i && tgt == TGT_NONE;
      we_q    <= req_i.we;
    end
  end

  // --------------------
  // response side
  // --------------------
  // writes and errors return zero data
  always_comb begin
    rsp_o     = '0;
    rsp_o.err = err_q;
    if (!we_q) begin
      case (tgt_q)
        TGT_ROM:   rsp_o.rdata = rom_rdata_i;
        TGT_CLINT: rsp_o.rdata = clint_rdata_i;
        TGT_SPM:   rsp_o.rdata = spm_rdata_i;
        default:   rsp_o.rdata = '0;
      endcase
    end
  end

  assign valid_o = valid_q;

endmodule

// ==== hw/boot_rom.sv ====
/* boot rom, contents loaded from a hex image at elaboration */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module boot_rom #(
  parameter int unsigned WORDS = `SUBSYS_ROM_WORDS
) (
  input  logic                      clk_i,
  input  logic                      sel_i,
  input  logic [`SUBSYS_ADDR_W-1:0] addr_i,
  output logic [`SUBSYS_DATA_W-1:0] rdata_o
);

  localparam int unsigned IDX_W = $clog2(WORDS);

  logic [`SUBSYS_DATA_W-1:0] mem [WORDS];

  initial begin
    $readmemh("hw/bootrom.hex", mem);
  end

  // one 64-bit word per 8 bytes
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= mem[addr_i[IDX_W+2:3]];
    end
  end

endmodule

// ==== hw/bootrom.hex ====
// boot rom image, one 64-bit word per line in hex, word 0 first
00000297_02028293
30529073_00000513
0ff0000f_10500073
00a00593_00b50633
fe060ee3_00c6a023
0000006f_00100073
1c000137_00010117
deadbeef_cafef00d
0123456789abcdef
fedcba9876543210
a5a5a5a5_5a5a5a5a
00000000_ffffffff
8000000000000001
13579bdf_2468ace0
7fffffff_80000000
3c3c3c3c_c3c3c3c3

// ==== hw/clint_timer.sv ====
/* core-local interruptor
   software interrupt bit, rtc driven machine timer and compare */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module clint_timer import subsys_pkg::*; (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     rtc_i,
  input  logic     sel_i,
  input  bus_req_t req_i,
  output data_t    rdata_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  localparam logic [15:0] MSIP_OFS     = `SUBSYS_CLINT_MSIP_OFS;
  localparam logic [15:0] MTIMECMP_OFS = `SUBSYS_CLINT_MTIMECMP_OFS;
  localparam logic [15:0] MTIME_OFS    = `SUBSYS_CLINT_MTIME_OFS;

  logic       msip_q;
  data_t      mtimecmp_q;
  data_t      mtime_q;
  logic       timer_irq_q;
  logic [2:0] rtc_q;
  logic       rtc_rise;
  logic       div_q;
  logic       hit_msip;
  logic       hit_cmp;
  logic       hit_time;

  // word offset within the window, low three bits dropped
  assign hit_msip = req_i.addr[15:3] == MSIP_OFS[15:3];
  assign hit_cmp  = req_i.addr[15:3] == MTIMECMP_OFS[15:3];
  assign hit_time = req_i.addr[15:3] == MTIME_OFS[15:3];

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else if (sel_i && req_i.we) begin
      if (hit_msip && req_i.be[0]) begin
        msip_q <= req_i.wdata[0];
      end
      if (hit_cmp) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req_i.be[b]) begin
            mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // --------------------
  // rtc sync and timer
  // --------------------
  // two sync flops, the third one finds the edge
  assign rtc_rise = rtc_q[1] && !rtc_q[2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q       <= '0;
      div_q       <= 1'b0;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) begin
        div_q <= !div_q;
        // tick on the 1 -> 0 turn of the divider
        if (div_q) begin
          mtime_q <= mtime_q + 1'b1;
        end
      end
      timer_irq_q <= mtime_q >= mtimecmp_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.we) begin
        rdata_o <= '0;
      end else if (hit_msip) begin
        rdata_o <= data_t'(msip_q);
      end else if (hit_cmp) begin
        rdata_o <= mtimecmp_q;
      end else if (hit_time) begin
        rdata_o <= mtime_q;
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

endmodule

// ==== hw/debug_req_gate.sv ====
/* holds back debug requests for a fixed time after reset */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module debug_req_gate import subsys_pkg::*; (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  dbg_cnt_t cnt_q;
  logic     debug_req_q;

  // boot code runs first, then debug may halt the core
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q       <= dbg_cnt_t'(`SUBSYS_DEBUG_DELAY);
      debug_req_q <= 1'b0;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      debug_req_q <= (cnt_q != '0) ? 1'b0 : debug_req_i;
    end
  end

  assign debug_req_o = debug_req_q;

endmodule

// ==== hw/periph_subsystem.sv ====
/* peripheral subsystem top
   request cut, address decoder, rom, clint, scratchpad and response cut */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module periph_subsystem import subsys_pkg::*; (
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  rtc_i,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  data_t req_wdata_i,
  input  strb_t req_be_i,
  output logic  rsp_valid_o,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o,
  input  logic  debug_req_i,
  output logic  debug_req_o,
  output logic  timer_irq_o,
  output logic  ipi_o
);

  bus_req_t host_req;
  logic     cut_valid;
  bus_req_t cut_req;
  logic     rom_sel;
  logic     clint_sel;
  logic     spm_sel;
  bus_req_t tgt_req;
  data_t    rom_rdata;
  data_t    clint_rdata;
  data_t    spm_rdata;
  logic     dec_valid;
  bus_rsp_t dec_rsp;
  bus_rsp_t host_rsp;

  assign host_req = '{
    addr:  req_addr_i,
    we:    req_we_i,
    wdata: req_wdata_i,
    be:    req_be_i
  };

  // --------------------
  // request path
  // --------------------
  pipe_cut #(
    .payload_t  ( bus_req_t   )
  ) i_req_cut (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .valid_i    ( req_valid_i ),
    .data_i     ( host_req    ),
    .valid_o    ( cut_valid   ),
    .data_o     ( cut_req     )
  );

  addr_decoder i_addr_decoder (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .valid_i       ( cut_valid   ),
    .req_i         ( cut_req     ),
    .rom_sel_o     ( rom_sel     ),
    .clint_sel_o   ( clint_sel   ),
    .spm_sel_o     ( spm_sel     ),
    .tgt_req_o     ( tgt_req     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .spm_rdata_i   ( spm_rdata   ),
    .valid_o       ( dec_valid   ),
    .rsp_o         ( dec_rsp     )
  );

  // --------------------
  // targets
  // --------------------
  boot_rom #(
    .WORDS   ( `SUBSYS_ROM_WORDS )
  ) i_boot_rom (
    .clk_i   ( clk_i             ),
    .sel_i   ( rom_sel           ),
    .addr_i  ( tgt_req.addr      ),
    .rdata_o ( rom_rdata         )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .sel_i       ( clint_sel   ),
    .req_i       ( tgt_req     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  scratchpad_ram #(
    .WORDS   ( `SUBSYS_SPM_WORDS )
  ) i_scratchpad_ram (
    .clk_i   ( clk_i             ),
    .sel_i   ( spm_sel           ),
    .req_i   ( tgt_req           ),
    .rdata_o ( spm_rdata         )
  );

  // --------------------
  // response path
  // --------------------
  pipe_cut #(
    .payload_t  ( bus_rsp_t   )
  ) i_rsp_cut (
    .clk_i      ( clk_i       ),
    .ndmreset_n ( ndmreset_n  ),
    .valid_i    ( dec_valid   ),
    .data_i     ( dec_rsp     ),
    .valid_o    ( rsp_valid_o ),
    .data_o     ( host_rsp    )
  );

  assign rsp_rdata_o = host_rsp.rdata;
  assign rsp_err_o   = host_rsp.err;

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== hw/pipe_cut.sv ====
/* single stage register slice for any payload type */

`timescale 1ns/1ps

module pipe_cut import subsys_pkg::*; #(
  parameter type payload_t = bus_req_t
) (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== hw/scratchpad_ram.sv ====
/* scratchpad sram, 64-bit words with byte enables */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module scratchpad_ram import subsys_pkg::*; #(
  parameter int unsigned WORDS = `SUBSYS_SPM_WORDS
) (
  input  logic     clk_i,
  input  logic     sel_i,
  input  bus_req_t req_i,
  output data_t    rdata_o
);

  localparam int unsigned IDX_W = $clog2(WORDS);

  data_t             mem [WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = req_i.addr[IDX_W+2:3];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (req_i.we) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req_i.be[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

// ==== hw/subsys_defines.svh ====
/* peripheral subsystem parameters
   bus widths, address map, memory depths and the debug release delay */

`ifndef SUBSYS_DEFINES_SVH
`define SUBSYS_DEFINES_SVH

// --------------------
// bus widths
// --------------------
`define SUBSYS_ADDR_W 32
`define SUBSYS_DATA_W 64

// --------------------
// address map
// --------------------
`define SUBSYS_ROM_BASE   32'h0001_0000
`define SUBSYS_ROM_WORDS  16
`define SUBSYS_CLINT_BASE 32'h0200_0000
`define SUBSYS_CLINT_LEN  32'h0000_C000
// scratchpad window is 0x1000 bytes
`define SUBSYS_SPM_BASE   32'h1C00_0000
`define SUBSYS_SPM_WORDS  512

// cycles the core gets to run boot code before debug can halt it
`define SUBSYS_DEBUG_DELAY 500

// clint register offsets inside its window
`define SUBSYS_CLINT_MSIP_OFS     16'h0000
`define SUBSYS_CLINT_MTIMECMP_OFS 16'h4000
`define SUBSYS_CLINT_MTIME_OFS    16'hBFF8

`endif

// ==== hw/subsys_pkg.sv ====
/* peripheral subsystem types
   bus request and response words, target encoding */

`include "subsys_defines.svh"

package subsys_pkg;

  typedef logic [`SUBSYS_ADDR_W-1:0]   addr_t;
  typedef logic [`SUBSYS_DATA_W-1:0]   data_t;
  typedef logic [`SUBSYS_DATA_W/8-1:0] strb_t;

  // --------------------
  // bus payloads
  // --------------------
  // 105 bits
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t be;
  } bus_req_t;

  // 65 bits
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // decoded destination of a request
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_SPM,
    TGT_NONE
  } target_e;

  // post-reset debug hold-off counter
  typedef logic [$clog2(`SUBSYS_DEBUG_DELAY+1)-1:0] dbg_cnt_t;

endpackage

// ==== project.f ====
+incdir+hw
hw/subsys_pkg.sv
hw/pipe_cut.sv
hw/addr_decoder.sv
hw/clint_timer.sv
hw/boot_rom.sv
hw/scratchpad_ram.sv
hw/debug_req_gate.sv
hw/periph_subsystem.sv
tests/tb_periph_subsystem.sv

// ==== tests/tb_periph_subsystem.sv ====
/* directed testbench for the peripheral subsystem
   drives host requests, rtc and debug inputs and checks the responses */

`timescale 1ns/1ps

`include "subsys_defines.svh"

module tb_periph_subsystem;

  localparam int          TIMEOUT  = 1000;
  localparam logic [31:0] UNMAPPED = 32'h3000_0000;
  localparam logic [31:0] MSIP     = `SUBSYS_CLINT_BASE + 32'h0;
  localparam logic [31:0] MTIMECMP = `SUBSYS_CLINT_BASE + 32'h4000;
  localparam logic [31:0] MTIME    = `SUBSYS_CLINT_BASE + 32'hBFF8;

  logic        clk_i = 1'b0;
  logic        ndmreset_n;
  logic        rtc_i;
  logic        req_valid_i;
  logic [31:0] req_addr_i;
  logic        req_we_i;
  logic [63:0] req_wdata_i;
  logic [7:0]  req_be_i;
  logic        rsp_valid_o;
  logic [63:0] rsp_rdata_o;
  logic        rsp_err_o;
  logic        debug_req_i;
  logic        debug_req_o;
  logic        timer_irq_o;
  logic        ipi_o;

  int          cyc = 0;
  int          rel_cyc = 0;
  int          errors = 0;
  int          passes = 0;
  logic        timed_out = 1'b0;
  logic [31:0] lcg_state = 32'd86571;
  logic [63:0] exp_rom [16];
  logic [63:0] spm_model [16];
  int          req_cyc_q [$];
  logic [63:0] rsp_data_q [$];
  logic        rsp_err_q [$];
  int          rsp_cyc_q [$];

  periph_subsystem periph_subsystem_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_we_i    ( req_we_i    ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (ndmreset_n) begin
      rel_cyc <= rel_cyc + 1;
    end
  end

  // sample on the falling edge, away from the drive edge
  always @(negedge clk_i) begin
    if (req_valid_i) begin
      req_cyc_q.push_back(cyc);
    end
    if (rsp_valid_o) begin
      rsp_data_q.push_back(rsp_rdata_o);
      rsp_err_q.push_back(rsp_err_o);
      rsp_cyc_q.push_back(cyc);
    end
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w, input logic [63:0] new_w,
                                              input logic [7:0] be);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // results after a lost response mean nothing
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (timed_out) begin
      return;
    end
    if (actual !== expected) begin
      $display("** Error %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      errors++;
    end else begin
      passes++;
    end
  endtask

  task automatic finish_run();
    $display("checks passed: %0d, errors: %0d", passes, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic send_req(input logic [31:0] addr, input logic we, input logic [63:0] wdata,
                          input logic [7:0] be);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_we_i    <= we;
    req_wdata_i <= wdata;
    req_be_i    <= be;
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    req_we_i    <= 1'b0;
  endtask

  task automatic wait_rsp();
    int n;
    n = 0;
    while (rsp_data_q.size() == 0 && !timed_out && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (rsp_data_q.size() == 0 && !timed_out) begin
      $display("timeout: the DUT gave no response within %0d cycles", TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_release_cycles(input int target);
    int n;
    n = 0;
    while (rel_cyc < target && !timed_out && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (rel_cyc < target && !timed_out) begin
      $display("timeout: cycle %0d after reset release was never reached", target);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // pops one response and checks it came 3 cycles after its request
  task automatic collect_rsp(output logic [63:0] data, output logic err);
    int issued;
    int arrived;
    data = '0;
    err  = 1'b0;
    wait_rsp();
    if (rsp_data_q.size() != 0) begin
      data    = rsp_data_q.pop_front();
      err     = rsp_err_q.pop_front();
      arrived = rsp_cyc_q.pop_front();
      if (req_cyc_q.size() == 0) begin
        $display("a response arrived with no request outstanding");
        errors++;
      end else begin
        issued = req_cyc_q.pop_front();
        check_value("rsp latency", 64'(arrived - issued), 64'd3);
      end
    end
  endtask

  task automatic expect_rsp(input string name, input logic [63:0] exp_data, input logic exp_err);
    logic [63:0] data;
    logic        err;
    collect_rsp(data, err);
    check_value({name, " rsp_rdata_o"}, data, exp_data);
    check_value({name, " rsp_err_o"}, 64'(err), 64'(exp_err));
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [63:0] exp_data);
    send_req(addr, 1'b0, 64'h0, 8'h00);
    bus_idle();
    expect_rsp(name, exp_data, 1'b0);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [63:0] data);
    logic err;
    send_req(addr, 1'b0, 64'h0, 8'h00);
    bus_idle();
    collect_rsp(data, err);
    check_value("read rsp_err_o", 64'(err), 64'd0);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] be);
    send_req(addr, 1'b1, data, be);
    bus_idle();
    expect_rsp("write", 64'h0, 1'b0);
  endtask

  // rtc is slow against clk_i, so each level lasts a few cycles
  task automatic pulse_rtc();
    @(posedge clk_i);
    rtc_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rtc_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  function automatic logic [31:0] spm_addr(input int i);
    return `SUBSYS_SPM_BASE + 32'(((i * 37 + 5) % 512) * 8 + (i % 8));
  endfunction

  // --------------------
  // tests
  // --------------------
  task automatic debug_gate();
    int err0;
    int n;
    err0 = errors;
    wait_release_cycles(400);
    check_value("debug_req_o", 64'(debug_req_o), 64'd0);
    wait_release_cycles(600);
    check_value("debug_req_o", 64'(debug_req_o), 64'd1);
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    n = 0;
    while (debug_req_o !== 1'b0 && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    check_value("debug_req_o", 64'(debug_req_o), 64'd0);
    $display("debug gate test done, %0d errors", errors - err0);
  endtask

  task automatic rom_reads();
    int err0;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      send_req(`SUBSYS_ROM_BASE + 32'(8 * i), 1'b0, 64'h0, 8'h00);
    end
    bus_idle();
    for (int i = 0; i < 16; i++) begin
      expect_rsp("rom read", exp_rom[i], 1'b0);
    end
    // a write leaves the image untouched
    write_word(`SUBSYS_ROM_BASE + 32'd16, rand_word(), 8'hff);
    read_expect("rom after write", `SUBSYS_ROM_BASE + 32'd16, exp_rom[2]);
    $display("rom test done, %0d errors", errors - err0);
  endtask

  task automatic scratchpad_access();
    int          err0;
    logic [63:0] wdata;
    logic [31:0] r;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      wdata = rand_word();
      spm_model[i] = wdata;
      send_req(spm_addr(i), 1'b1, wdata, 8'hff);
    end
    bus_idle();
    for (int i = 0; i < 16; i++) begin
      expect_rsp("spm fill", 64'h0, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      wdata = rand_word();
      r = lcg_next();
      spm_model[i] = merge_bytes(spm_model[i], wdata, r[15:8]);
      send_req(spm_addr(i), 1'b1, wdata, r[15:8]);
    end
    bus_idle();
    for (int i = 0; i < 16; i++) begin
      expect_rsp("spm partial write", 64'h0, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      send_req(spm_addr(i), 1'b0, 64'h0, 8'h00);
    end
    bus_idle();
    for (int i = 0; i < 16; i++) begin
      expect_rsp("spm read", spm_model[i], 1'b0);
    end
    $display("scratchpad test done, %0d errors", errors - err0);
  endtask

  task automatic unmapped_access();
    int err0;
    err0 = errors;
    send_req(UNMAPPED, 1'b0, 64'h0, 8'h00);
    send_req(`SUBSYS_ROM_BASE + 32'd40, 1'b0, 64'h0, 8'h00);
    send_req(UNMAPPED + 32'h100, 1'b1, rand_word(), 8'hff);
    bus_idle();
    expect_rsp("unmapped read", 64'h0, 1'b1);
    expect_rsp("rom after error", exp_rom[5], 1'b0);
    expect_rsp("unmapped write", 64'h0, 1'b1);
    $display("unmapped address test done, %0d errors", errors - err0);
  endtask

  task automatic software_irq();
    int err0;
    err0 = errors;
    write_word(MSIP, 64'h1, 8'hff);
    check_value("ipi_o", 64'(ipi_o), 64'd1);
    read_expect("msip set", MSIP, 64'h1);
    write_word(MSIP, 64'h0, 8'hff);
    check_value("ipi_o", 64'(ipi_o), 64'd0);
    read_expect("msip clear", MSIP, 64'h0);
    $display("software interrupt test done, %0d errors", errors - err0);
  endtask

  task automatic timer_compare();
    int          err0;
    int          n;
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] cmp;
    err0 = errors;
    read_word(MTIME, t0);
    repeat (10) pulse_rtc();
    read_word(MTIME, t1);
    // two rtc edges per tick
    check_value("mtime delta", t1 - t0, 64'd5);
    cmp = t1 + 64'd3;
    write_word(MTIMECMP, cmp, 8'hff);
    repeat (2) @(negedge clk_i);
    check_value("timer_irq_o", 64'(timer_irq_o), 64'd0);
    read_expect("mtimecmp", MTIMECMP, cmp);
    n = 0;
    while (t1 < cmp && n < 10) begin
      check_value("timer_irq_o", 64'(timer_irq_o), 64'd0);
      pulse_rtc();
      pulse_rtc();
      read_word(MTIME, t1);
      n++;
    end
    check_value("mtime", t1, cmp);
    n = 0;
    while (timer_irq_o !== 1'b1 && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    check_value("timer_irq_o", 64'(timer_irq_o), 64'd1);
    write_word(MTIMECMP, '1, 8'hff);
    n = 0;
    while (timer_irq_o !== 1'b0 && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    check_value("timer_irq_o", 64'(timer_irq_o), 64'd0);
    $display("timer test done, %0d errors", errors - err0);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    req_be_i    = '0;
    // debug request already pending when reset releases
    debug_req_i = 1'b1;
    $readmemh("hw/bootrom.hex", exp_rom);
    repeat (10) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    // runs first, it counts from reset release
    debug_gate();
    rom_reads();
    scratchpad_access();
    unmapped_access();
    software_irq();
    timer_compare();
    repeat (5) @(negedge clk_i);
    if (rsp_data_q.size() != 0) begin
      $display("the DUT sent %0d responses that no request asked for", rsp_data_q.size());
      errors++;
    end
    finish_run();
  end

endmodule
